//--- lsu.f
common/lsu_pkg.sv
verilog/mem_req_gen.sv
verilog/load_align.sv
verilog/llsc_monitor.sv
dcache/dcache.sv
dcache/wb_mem_port.sv
verilog/lsu_top.sv
verif/wb_mem_model.sv
verif/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module lsu_tb -f lsu.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee sim.log
grep -q "^Everything OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/lsu_tb.sv
module lsu_tb;

    typedef struct packed {
        lsu_pkg::mem_op_e op;
        logic [31:0]      base;
        logic [31:0]      imm;
        logic [31:0]      wdata;
        logic [4:0]       op_arg;
        logic             exp_mis;
        logic             exp_sc;
        logic [3:0]       exp_xfers;
    } test_row_t;

    localparam int timeout_cycles = 60;
    localparam int n_rows         = 49;

    // op, base, imm, store data, cacop code, misalign, sc_ok, bus transfers
    localparam test_row_t rows [n_rows] = '{
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_b,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_b,  32'h10,  32'h1, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_b,  32'h10,  32'h2, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_b,  32'h10,  32'h3, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_bu, 32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_bu, 32'h10,  32'h1, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_bu, 32'h10,  32'h2, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_bu, 32'h10,  32'h3, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_h,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_h,  32'h10,  32'h2, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_hu, 32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_hu, 32'h10,  32'h2, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        // same index, other tag
        '{lsu_pkg::ld_w,  32'h110, 32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        // write-through stores, no allocate on a miss
        '{lsu_pkg::st_b,  32'h10,  32'h1, 32'h5A,       5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::st_h,  32'h20,  32'h2, 32'h1234BEEF, 5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ld_w,  32'h20,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::st_w,  32'h20,  32'h4, 32'hDEADBEEF, 5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::st_b,  32'h20,  32'h3, 32'h77,       5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ld_b,  32'h20,  32'h3, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h28, -32'sd4, 32'h0,       5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::st_h,  32'h10,  32'h0, 32'hCAFE8001, 5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ld_h,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        // misaligned accesses
        '{lsu_pkg::ld_h,  32'h10,  32'h1, 32'h0,        5'd0, 1'b1, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h10,  32'h2, 32'h0,        5'd0, 1'b1, 1'b0, 4'd0},
        '{lsu_pkg::st_h,  32'h10,  32'h3, 32'hFFFF,     5'd0, 1'b1, 1'b0, 4'd0},
        '{lsu_pkg::st_w,  32'h20,  32'h1, 32'h99999999, 5'd0, 1'b1, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        // ll.w and sc.w
        '{lsu_pkg::ll_w,  32'h30,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::sc_w,  32'h30,  32'h0, 32'h11112222, 5'd0, 1'b0, 1'b1, 4'd1},
        '{lsu_pkg::ld_w,  32'h30,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::sc_w,  32'h30,  32'h0, 32'h33334444, 5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h30,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ll_w,  32'h30,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::sc_w,  32'h34,  32'h0, 32'h55556666, 5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::sc_w,  32'h30,  32'h0, 32'h77778888, 5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h34,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        // cacop and ibar
        '{lsu_pkg::cacop, 32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::cacop, 32'h110, 32'h0, 32'h0,        5'd1, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::cacop, 32'h10,  32'h0, 32'h0,        5'd1, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h10,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1},
        '{lsu_pkg::ibar,  32'h0,   32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::cacop, 32'h130, 32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd0},
        '{lsu_pkg::ld_w,  32'h30,  32'h0, 32'h0,        5'd0, 1'b0, 1'b0, 4'd1}
    };

    logic               clk;
    logic               rst_n;
    lsu_pkg::exe_req_t  req;
    logic               req_valid;
    logic               req_ready;
    lsu_pkg::lsu_resp_t resp;
    logic               resp_valid;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [31:0]        wb_adr;
    logic [31:0]        wb_dat_w;
    logic [3:0]         wb_sel;
    logic [31:0]        wb_dat_r;
    logic               wb_ack;
    logic [31:0]        xfer_count;

    logic [31:0] shadow [256];
    int          errors;
    int          tests_run;
    int          failed_tests;
    bit          timed_out;

    lsu_top lsu_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    wb_mem_model mem_model_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .xfer_count (xfer_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // class 5 subtypes follow the op order, class 6 holds ll.w and sc.w
    function automatic lsu_pkg::ctrl_word_t ctrl_for(input lsu_pkg::mem_op_e op);
        lsu_pkg::ctrl_word_t c;
        c = '0;
        c.mem_class = lsu_pkg::class_normal;
        case (op)
            lsu_pkg::ld_b:  c.subtype = 5'd0;
            lsu_pkg::ld_h:  c.subtype = 5'd1;
            lsu_pkg::ld_w:  c.subtype = 5'd2;
            lsu_pkg::st_b:  c.subtype = 5'd3;
            lsu_pkg::st_h:  c.subtype = 5'd4;
            lsu_pkg::st_w:  c.subtype = 5'd5;
            lsu_pkg::ld_bu: c.subtype = 5'd6;
            lsu_pkg::ld_hu: c.subtype = 5'd7;
            lsu_pkg::ibar:  c.subtype = 5'd8;
            lsu_pkg::cacop: c.subtype = 5'd9;
            lsu_pkg::sc_w:  c.subtype = 5'd1;
            default:        c.subtype = 5'd0;
        endcase
        if (op == lsu_pkg::ll_w || op == lsu_pkg::sc_w)
            c.mem_class = lsu_pkg::class_atomic;
        return c;
    endfunction

    function automatic logic [31:0] expect_load(input lsu_pkg::mem_op_e op,
                                                input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] lane;
        word = shadow[addr[9:2]];
        lane = word >> (8 * int'(addr[1:0]));
        case (op)
            lsu_pkg::ld_b:                return {{24{lane[7]}}, lane[7:0]};
            lsu_pkg::ld_bu:               return {24'h0, lane[7:0]};
            lsu_pkg::ld_h:                return {{16{lane[15]}}, lane[15:0]};
            lsu_pkg::ld_hu:               return {16'h0, lane[15:0]};
            lsu_pkg::ld_w, lsu_pkg::ll_w: return word;
            default:                      return 32'h0;
        endcase
    endfunction

    // little endian, store data taken from the low bytes
    task automatic update_shadow(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        int lo;
        int n;
        lo = 8 * int'(addr[1:0]);
        case (op)
            lsu_pkg::st_b:               n = 1;
            lsu_pkg::st_h:               n = 2;
            lsu_pkg::st_w, lsu_pkg::sc_w: n = 4;
            default:                     n = 0;
        endcase
        for (int b = 0; b < n; b++)
            shadow[addr[9:2]][lo + 8*b +: 8] = wdata[8*b +: 8];
    endtask

    task automatic run_row(input int t, input test_row_t row);
        lsu_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [31:0]      count_before;
        logic [31:0]      exp_rdata;
        int               cycles;
        int               errs_before;
        op          = row.op;
        addr        = row.base + row.imm;
        errs_before = errors;
        exp_rdata   = expect_load(op, addr);
        tests_run++;
        cycles = 0;
        while (!req_ready && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready)
        begin
            $display("test %0d: timed out waiting for req_ready", t);
            failed_tests++;
            timed_out = 1'b1;
            return;
        end
        count_before = xfer_count;
        req.ctrl     = ctrl_for(op);
        req.base     = row.base;
        req.imm      = row.imm;
        req.wdata    = row.wdata;
        req.op_arg   = row.op_arg;
        req_valid    = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        cycles = 0;
        while (!resp_valid && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid)
        begin
            $display("test %0d: the LSU gave no response in time", t);
            failed_tests++;
            timed_out = 1'b1;
            return;
        end
        // no bus transfer means an answer in the cycle after acceptance
        if (row.exp_xfers == 4'd0)
            compare_value("resp_latency", cycles, 32'h0);
        compare_value("resp.misalign", {31'h0, resp.misalign}, {31'h0, row.exp_mis});
        compare_value("resp.sc_ok", {31'h0, resp.sc_ok}, {31'h0, row.exp_sc});
        compare_value("bus_transfers", xfer_count - count_before, {28'h0, row.exp_xfers});
        if (!row.exp_mis)
            compare_value("resp.rdata", resp.rdata, exp_rdata);
        if (!row.exp_mis && (op != lsu_pkg::sc_w || row.exp_sc))
            update_shadow(op, addr, row.wdata);
        if (errors == errs_before)
        begin
            $display("test %0d %s addr %h: ok", t, op.name(), addr);
        end
        else
        begin
            $display("test %0d %s addr %h: mismatch", t, op.name(), addr);
            failed_tests++;
        end
    endtask

    initial
    begin
        int errs_before;
        rst_n        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < 256; i++)
            shadow[i] = i * 32'h0101_0101 ^ 32'hA5A5_0000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int t = 0; t < n_rows && !timed_out; t++)
            run_row(t, rows[t]);

        // backing memory against the shadow copy
        if (!timed_out)
        begin
            errs_before = errors;
            tests_run++;
            for (int i = 0; i < 256; i++)
                compare_value($sformatf("mem[%0d]", i), mem_model_i.mem[i], shadow[i]);
            if (errors == errs_before)
            begin
                $display("memory contents: ok");
            end
            else
            begin
                $display("memory contents: mismatch");
                failed_tests++;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0 && failed_tests == 0 && !timed_out)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- verif/wb_mem_model.sv
module wb_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic [31:0] xfer_count
);

    logic [31:0] mem [256];
    logic [1:0]  delay;
    logic [1:0]  wait_cnt;
    logic [7:0]  word;

    assign word = wb_adr[9:2];

    // one seed for the whole run
    initial
    begin
        void'($urandom(32'h3d88));
    end

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_ack     <= 1'b0;
            wb_dat_r   <= '0;
            wait_cnt   <= '0;
            delay      <= '0;
            xfer_count <= '0;
            for (int i = 0; i < 256; i++)
                mem[i] <= i * 32'h0101_0101 ^ 32'hA5A5_0000;
        end
        else
        begin
            wb_ack <= 1'b0;
            // classic cycle, ack after a random number of wait states
            if (wb_cyc && wb_stb && !wb_ack)
            begin
                if (wait_cnt == delay)
                begin
                    wb_ack     <= 1'b1;
                    wait_cnt   <= '0;
                    delay      <= 2'($urandom % 32'd4);
                    xfer_count <= xfer_count + 32'd1;
                    if (wb_we)
                    begin
                        for (int b = 0; b < 4; b++)
                            if (wb_sel[b])
                                mem[word][8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                    else
                        wb_dat_r <= mem[word];
                end
                else
                    wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

//--- verilog/lsu_top.sv
module lsu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  lsu_pkg::exe_req_t   req,
    input  logic                req_valid,
    output logic                req_ready,
    output lsu_pkg::lsu_resp_t  resp,
    output logic                resp_valid,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [31:0]         wb_adr,
    output logic [31:0]         wb_dat_w,
    output logic [3:0]          wb_sel,
    input  logic [31:0]         wb_dat_r,
    input  logic                wb_ack
);

    lsu_pkg::exe_req_t    req_q;
    lsu_pkg::mem_access_t access;
    lsu_pkg::bus_cmd_t    cmd;
    lsu_pkg::mem_op_e     align_op;

    logic        accept;
    logic        busy;
    logic        cmd_valid;
    logic        bus_done;
    logic [31:0] bus_rdata;
    logic [31:0] raw_rdata;
    logic [31:0] load_data;
    logic        done;
    logic        sc_ok;
    logic        ll_set;
    logic        ll_clear;
    logic        reserve_hit;

    // one request in flight
    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (accept)
            req_q <= req;
    end

    mem_req_gen mem_req_gen_i (
        .req    (req_q),
        .access (access)
    );

    dcache dcache_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (accept),
        .access      (access),
        .bus_done    (bus_done),
        .bus_rdata   (bus_rdata),
        .reserve_hit (reserve_hit),
        .busy        (busy),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .raw_rdata   (raw_rdata),
        .done        (done),
        .sc_ok       (sc_ok),
        .ll_set      (ll_set),
        .ll_clear    (ll_clear)
    );

    llsc_monitor llsc_monitor_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ll_set      (ll_set),
        .ll_clear    (ll_clear),
        .addr        (access.addr),
        .reserve_hit (reserve_hit)
    );

    // misaligned loads return zero
    assign align_op = access.misalign ? lsu_pkg::op_none : access.op;

    load_align load_align_i (
        .raw    (raw_rdata),
        .op     (align_op),
        .offset (access.addr[1:0]),
        .data   (load_data)
    );

    wb_mem_port wb_mem_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .bus_done  (bus_done),
        .bus_rdata (bus_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel)
    );

    assign resp_valid    = done;
    assign resp.rdata    = load_data;
    assign resp.misalign = access.misalign;
    assign resp.sc_ok    = sc_ok;

endmodule

//--- dcache/wb_mem_port.sv
module wb_mem_port (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::bus_cmd_t cmd,
    input  logic              cmd_valid,
    input  logic [31:0]       wb_dat_r,
    input  logic              wb_ack,
    output logic              bus_done,
    output logic [31:0]       bus_rdata,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [31:0]       wb_adr,
    output logic [31:0]       wb_dat_w,
    output logic [3:0]        wb_sel
);

    typedef enum logic {
        p_idle,
        p_active
    } port_state_e;

    port_state_e state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= p_idle;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            bus_done <= 1'b0;
        end
        else
        begin
            bus_done <= 1'b0;
            case (state)
                p_idle:
                    if (cmd_valid)
                    begin
                        state  <= p_active;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= cmd.we;
                    end
                default:
                    // single transfer, release the bus right after ack
                    if (wb_ack)
                    begin
                        state    <= p_idle;
                        wb_cyc   <= 1'b0;
                        wb_stb   <= 1'b0;
                        wb_we    <= 1'b0;
                        bus_done <= 1'b1;
                    end
            endcase
        end
    end

    // command capture and read data
    always_ff @(posedge clk)
    begin
        if (state == p_idle && cmd_valid)
        begin
            wb_adr   <= cmd.addr;
            wb_dat_w <= cmd.wdata;
            wb_sel   <= cmd.sel;
        end
        if (state == p_active && wb_ack)
            bus_rdata <= wb_dat_r;
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc);

    a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> $stable(wb_adr));

endmodule

//--- dcache/dcache.sv
module dcache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  lsu_pkg::mem_access_t access,
    input  logic                 bus_done,
    input  logic [31:0]          bus_rdata,
    input  logic                 reserve_hit,
    output logic                 busy,
    output lsu_pkg::bus_cmd_t    cmd,
    output logic                 cmd_valid,
    output logic [31:0]          raw_rdata,
    output logic                 done,
    output logic                 sc_ok,
    output logic                 ll_set,
    output logic                 ll_clear
);

    lsu_pkg::cache_state_e state;

    logic [lsu_pkg::cache_lines-1:0] valid_q;
    logic [lsu_pkg::tag_bits-1:0]    tag_arr  [lsu_pkg::cache_lines];
    logic [lsu_pkg::xlen-1:0]        data_arr [lsu_pkg::cache_lines];

    logic [lsu_pkg::index_bits-1:0] idx;
    logic [lsu_pkg::tag_bits-1:0]   tag;
    logic                           hit;
    logic                           quick_done;
    logic                           go_read;
    logic                           go_write;
    logic                           fill;
    logic                           inval;
    logic                           wr_hit;

    assign idx = access.addr[lsu_pkg::off_bits +: lsu_pkg::index_bits];
    assign tag = access.addr[lsu_pkg::xlen-1 -: lsu_pkg::tag_bits];
    assign hit = valid_q[idx] && (tag_arr[idx] == tag);

    // what the lookup cycle decides
    always_comb
    begin
        quick_done = 1'b0;
        go_read    = 1'b0;
        go_write   = 1'b0;
        if (state == lsu_pkg::lookup)
        begin
            if (access.misalign || access.op == lsu_pkg::ibar ||
                access.op == lsu_pkg::cacop || access.op == lsu_pkg::op_none)
                quick_done = 1'b1;
            else if (access.is_write)
            begin
                // failed sc.w never reaches the bus
                if (access.op == lsu_pkg::sc_w && !reserve_hit)
                    quick_done = 1'b1;
                else
                    go_write = 1'b1;
            end
            else if (hit)
                quick_done = 1'b1;
            else
                go_read = 1'b1;
        end
    end

    assign fill   = (state == lsu_pkg::bus_read) && bus_done;
    assign wr_hit = go_write && hit;
    assign inval  = (state == lsu_pkg::lookup) && (access.op == lsu_pkg::cacop) &&
                    ((access.cacop_code == lsu_pkg::idx_inval) ||
                     (access.cacop_code == lsu_pkg::hit_inval && hit));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= lsu_pkg::idle;
            valid_q   <= '0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= go_read || go_write;
            case (state)
                lsu_pkg::idle:
                    if (start)
                        state <= lsu_pkg::lookup;
                lsu_pkg::lookup:
                    if (go_read)
                        state <= lsu_pkg::bus_read;
                    else if (go_write)
                        state <= lsu_pkg::bus_write;
                    else
                        state <= lsu_pkg::idle;
                lsu_pkg::bus_read, lsu_pkg::bus_write:
                    if (bus_done)
                        state <= lsu_pkg::respond;
                default:
                    state <= lsu_pkg::idle;
            endcase
            if (fill)
                valid_q[idx] <= 1'b1;
            else if (inval)
                valid_q[idx] <= 1'b0;
        end
    end

    // refill on read miss, byte merge on write hit
    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= bus_rdata;
        end
        else if (wr_hit)
        begin
            for (int b = 0; b < 4; b++)
                if (access.strb[b])
                    data_arr[idx][8*b +: 8] <= access.wdata[8*b +: 8];
        end
    end

    // bus command, reads always fetch the whole word
    assign cmd.addr  = {access.addr[lsu_pkg::xlen-1:2], 2'b00};
    assign cmd.wdata = access.wdata;
    assign cmd.sel   = access.is_write ? access.strb : 4'b1111;
    assign cmd.we    = access.is_write;

    assign busy      = (state != lsu_pkg::idle);
    assign done      = quick_done || (state == lsu_pkg::respond);
    assign raw_rdata = data_arr[idx];
    assign sc_ok     = (state == lsu_pkg::respond) && (access.op == lsu_pkg::sc_w);
    assign ll_set    = done && (access.op == lsu_pkg::ll_w) && !access.misalign;
    assign ll_clear  = done && (access.op == lsu_pkg::sc_w);

    a_cmd_in_bus_state: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |-> (state == lsu_pkg::bus_read || state == lsu_pkg::bus_write));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

//--- verilog/llsc_monitor.sv
module llsc_monitor (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ll_set,
    input  logic                     ll_clear,
    input  logic [lsu_pkg::xlen-1:0] addr,
    output logic                     reserve_hit
);

    logic [lsu_pkg::xlen-3:0] resv_addr;
    logic                     resv_valid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            resv_valid <= 1'b0;
        else if (ll_set)
            resv_valid <= 1'b1;
        else if (ll_clear)
            resv_valid <= 1'b0;
    end

    // word address of the reservation
    always_ff @(posedge clk)
    begin
        if (ll_set)
            resv_addr <= addr[lsu_pkg::xlen-1:2];
    end

    assign reserve_hit = resv_valid && (resv_addr == addr[lsu_pkg::xlen-1:2]);

endmodule

//--- verilog/load_align.sv
module load_align (
    input  logic [31:0]      raw,
    input  lsu_pkg::mem_op_e op,
    input  logic [1:0]       offset,
    output logic [31:0]      data
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane select from the byte offset
    always_comb
    begin
        case (offset)
            2'b00:   byte_lane = raw[7:0];
            2'b01:   byte_lane = raw[15:8];
            2'b10:   byte_lane = raw[23:16];
            default: byte_lane = raw[31:24];
        endcase
    end

    assign half_lane = offset[1] ? raw[31:16] : raw[15:0];

    always_comb
    begin
        case (op)
            lsu_pkg::ld_b:
                data = {{24{byte_lane[7]}}, byte_lane};
            lsu_pkg::ld_bu:
                data = {24'b0, byte_lane};
            lsu_pkg::ld_h:
                data = {{16{half_lane[15]}}, half_lane};
            lsu_pkg::ld_hu:
                data = {16'b0, half_lane};
            lsu_pkg::ld_w, lsu_pkg::ll_w:
                data = raw;
            // stores, sc.w, ibar and cacop return nothing
            default:
                data = 32'b0;
        endcase
    end

endmodule

//--- verilog/mem_req_gen.sv
module mem_req_gen (
    input  lsu_pkg::exe_req_t    req,
    output lsu_pkg::mem_access_t access
);

    logic [lsu_pkg::xlen-1:0] addr;
    logic [1:0]               off;
    lsu_pkg::mem_op_e         op;
    logic                     is_byte;
    logic                     is_half;
    logic                     is_word;
    logic                     misalign;

    assign addr = req.base + req.imm;
    assign off  = addr[1:0];

    // class and subtype to operation
    always_comb
    begin
        op = lsu_pkg::op_none;
        if (req.ctrl.mem_class == lsu_pkg::class_normal)
        begin
            case (req.ctrl.subtype)
                5'd0:    op = lsu_pkg::ld_b;
                5'd1:    op = lsu_pkg::ld_h;
                5'd2:    op = lsu_pkg::ld_w;
                5'd3:    op = lsu_pkg::st_b;
                5'd4:    op = lsu_pkg::st_h;
                5'd5:    op = lsu_pkg::st_w;
                5'd6:    op = lsu_pkg::ld_bu;
                5'd7:    op = lsu_pkg::ld_hu;
                5'd8:    op = lsu_pkg::ibar;
                5'd9:    op = lsu_pkg::cacop;
                default: op = lsu_pkg::op_none;
            endcase
        end
        else if (req.ctrl.mem_class == lsu_pkg::class_atomic)
        begin
            case (req.ctrl.subtype)
                5'd0:    op = lsu_pkg::ll_w;
                5'd1:    op = lsu_pkg::sc_w;
                default: op = lsu_pkg::op_none;
            endcase
        end
    end

    // access size
    always_comb
    begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        case (op)
            lsu_pkg::ld_b, lsu_pkg::ld_bu, lsu_pkg::st_b: is_byte = 1'b1;
            lsu_pkg::ld_h, lsu_pkg::ld_hu, lsu_pkg::st_h: is_half = 1'b1;
            lsu_pkg::ld_w, lsu_pkg::st_w,
            lsu_pkg::ll_w, lsu_pkg::sc_w:                 is_word = 1'b1;
            default: ;
        endcase
    end

    assign misalign = (is_half && off[0]) || (is_word && (off != 2'b00));

    // little endian lanes, no strobes on a misaligned access
    always_comb
    begin
        access.strb  = 4'b0000;
        access.wdata = '0;
        if (!misalign)
        begin
            if (is_byte)
            begin
                access.strb  = 4'b0001 << off;
                access.wdata = {24'b0, req.wdata[7:0]} << {off, 3'b000};
            end
            else if (is_half)
            begin
                access.strb  = off[1] ? 4'b1100 : 4'b0011;
                access.wdata = {16'b0, req.wdata[15:0]} << {off[1], 4'b0000};
            end
            else if (is_word)
            begin
                access.strb  = 4'b1111;
                access.wdata = req.wdata;
            end
        end
    end

    assign access.addr       = addr;
    assign access.op         = op;
    assign access.misalign   = misalign;
    assign access.cacop_code = lsu_pkg::cacop_code_e'(req.op_arg);
    assign access.is_write   = (op == lsu_pkg::st_b) || (op == lsu_pkg::st_h) ||
                               (op == lsu_pkg::st_w) || (op == lsu_pkg::sc_w);

endmodule

//--- common/lsu_pkg.sv
package lsu_pkg;

    // datapath and cache geometry
    localparam int xlen        = 32;
    localparam int off_bits    = 2;
    localparam int cache_lines = 64;
    localparam int index_bits  = 6;
    localparam int tag_bits    = xlen - index_bits - off_bits;

    // type field of the control word, anything else is not a memory op
    typedef enum logic [3:0] {
        class_none   = 4'd0,
        class_normal = 4'd5,
        class_atomic = 4'd6
    } mem_class_e;

    typedef enum logic [3:0] {
        ld_b    = 4'd0,
        ld_h    = 4'd1,
        ld_w    = 4'd2,
        st_b    = 4'd3,
        st_h    = 4'd4,
        st_w    = 4'd5,
        ld_bu   = 4'd6,
        ld_hu   = 4'd7,
        ibar    = 4'd8,
        cacop   = 4'd9,
        ll_w    = 4'd10,
        sc_w    = 4'd11,
        op_none = 4'd15
    } mem_op_e;

    typedef enum logic [4:0] {
        idx_inval = 5'd0,
        hit_inval = 5'd1
    } cacop_code_e;

    typedef enum logic [2:0] {
        idle,
        lookup,
        bus_read,
        bus_write,
        respond
    } cache_state_e;

    // execute-stage control word, subtype in 11..7 and class in 3..0
    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic [4:0]  subtype;
        logic [2:0]  rsvd_lo;
        mem_class_e  mem_class;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t      ctrl;
        logic [xlen-1:0] base;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] wdata;
        // cacop code
        logic [4:0]      op_arg;
    } exe_req_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [3:0]      strb;
        logic [xlen-1:0] wdata;
        mem_op_e         op;
        logic            is_write;
        logic            misalign;
        cacop_code_e     cacop_code;
    } mem_access_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            misalign;
        logic            sc_ok;
    } lsu_resp_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [3:0]      sel;
        logic            we;
    } bus_cmd_t;

endpackage
